// ==== src/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction queue geometry
`define LB_DEPTH 32

// Count must be able to hold LB_DEPTH itself
`define LB_COUNT_W 6

// Fetch is told to stop while count is above this level
// This leaves room for requests already in flight
`define LB_STOP_LEVEL 26

// Opcode field checked for privileged instructions
`define OPC_FIELD_MSB 30
`define OPC_FIELD_LSB 21

`endif

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

	// Low six bits of the MMU page flags
	typedef struct packed {
		logic [1:0] user_level;   // Zero means kernel only page
		logic       exec;         // Page is executable
		logic [1:0] reserved;
		logic       valid;        // Page is present
	} mmu_flags_t;

	// Fault bits carried with every buffered instruction
	typedef struct packed {
		logic page_fault;
		logic privilege_error;
		logic invalid_inst;
	} fault_t;

	// One queue entry, 102 bits
	typedef struct packed {
		fault_t      fault;
		logic        paging_ena;
		logic        kernel_access;
		logic        branch_predict;
		logic [31:0] branch_predict_addr;
		logic [31:0] inst;
		logic [31:0] pc;
	} lb_entry_t;

	// Opcodes that trap when issued in user mode
	typedef enum logic [9:0] {
		OPC_SRTISR  = 10'h140,
		OPC_SRKPDTR = 10'h141,
		OPC_SRPDTW  = 10'h142,
		OPC_SRIEIW  = 10'h143,
		OPC_SRTISW  = 10'h144,
		OPC_SRKPDTW = 10'h145,
		OPC_SRMMUW  = 10'h146,
		OPC_HALT    = 10'h1f0,
		OPC_IDTS    = 10'h1f1
	} priv_opcode_e;

endpackage

// ==== src/fetch_fault_check.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module fetch_fault_check (
	input  wire logic                 paging_ena,
	input  wire logic                 kernel_access,  // 1 = kernel mode
	input  wire logic                 upstream_page_fault,
	input  wire fetch_pkg::mmu_flags_t mmu_flags,
	input  wire logic [31:0]          inst,
	output fetch_pkg::fault_t         fault
);

	logic [`OPC_FIELD_MSB-`OPC_FIELD_LSB:0] opcode;
	logic user_mode;
	logic page_missing;
	logic page_no_exec;
	logic page_kernel_only;
	logic priv_opcode;

	assign opcode    = inst[`OPC_FIELD_MSB:`OPC_FIELD_LSB];
	assign user_mode = !kernel_access;

	// Page checks only mean something with paging on
	always_comb begin
		page_missing     = 1'b0;
		page_no_exec     = 1'b0;
		page_kernel_only = 1'b0;
		if (paging_ena) begin
			page_missing = !mmu_flags.valid;
			page_no_exec = !mmu_flags.exec;
			// Kernel only page fetched from an executable mapping
			if (mmu_flags.exec && mmu_flags.user_level == 2'd0) begin
				page_kernel_only = 1'b1;
			end
		end
	end

	// Privileged opcode decode, independent of paging
	always_comb begin
		case (opcode)
			fetch_pkg::OPC_SRTISR,
			fetch_pkg::OPC_SRKPDTR,
			fetch_pkg::OPC_SRPDTW,
			fetch_pkg::OPC_SRIEIW,
			fetch_pkg::OPC_SRTISW,
			fetch_pkg::OPC_SRKPDTW,
			fetch_pkg::OPC_SRMMUW,
			fetch_pkg::OPC_HALT,
			fetch_pkg::OPC_IDTS: priv_opcode = 1'b1;
			default:             priv_opcode = 1'b0;
		endcase
	end

	// Combine into the three fault bits
	always_comb begin
		fault.page_fault   = upstream_page_fault || page_missing;
		fault.invalid_inst = page_no_exec;
		// Kernel mode never raises a privilege error
		fault.privilege_error = user_mode && (page_kernel_only || priv_opcode);
	end

endmodule

`default_nettype wire

// ==== src/inst_sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module inst_sync_fifo (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  flush,     // Empties the queue
	input  wire logic                  wr_en,
	input  wire fetch_pkg::lb_entry_t  wr_data,
	input  wire logic                  rd_en,
	output fetch_pkg::lb_entry_t       rd_data,
	output logic                       full,
	output logic                       empty,
	output logic [`LB_COUNT_W-1:0]     count
);

	localparam int PTR_W = $clog2(`LB_DEPTH);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`LB_DEPTH - 1);

	fetch_pkg::lb_entry_t mem [`LB_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr_next;
	logic [PTR_W-1:0] rd_ptr_next;

	// Wrap explicitly so a non power of two depth still works
	assign wr_ptr_next = (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
	assign rd_ptr_next = (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;

	assign full  = (count == `LB_COUNT_W'(`LB_DEPTH));
	assign empty = (count == '0);

	// Head is always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr_next;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr_next;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Idle or push and pop together
			endcase
		end
	end

	// Storage array
	always_ff @(posedge clock) begin
		if (wr_en && !flush) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	a_no_write_when_full: assert property (
		@(posedge clock) disable iff (reset) full |-> !wr_en
	);

	a_no_read_when_empty: assert property (
		@(posedge clock) disable iff (reset) empty |-> !rd_en
	);

	// Occupancy bound, tracked across edges
	a_count_bounded: assert property (
		@(posedge clock) disable iff (reset) count <= `LB_COUNT_W'(`LB_DEPTH)
	);

endmodule

`default_nettype wire

// ==== src/loopbuffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defines.svh"

module loopbuffer (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               free_refresh,   // One cycle flush strobe
	// From fetch
	input  wire logic               prev_inst_valid,
	input  wire logic               prev_pagefault,
	input  wire logic [13:0]        prev_mmu_flags,
	input  wire logic               prev_paging_ena,
	input  wire logic               prev_kernel_access,
	input  wire logic               prev_branch_predict,
	input  wire logic [31:0]        prev_branch_predict_addr,
	input  wire logic [31:0]        prev_inst,
	input  wire logic [31:0]        prev_pc,
	output logic                    prev_fetch_stop,
	output logic                    prev_lock,
	// To decode
	output logic                    next_inst_valid,
	output fetch_pkg::lb_entry_t    next_entry,
	input  wire logic               next_lock
);

	fetch_pkg::mmu_flags_t mmu_flags;
	fetch_pkg::fault_t     fault;
	fetch_pkg::lb_entry_t  wr_entry;

	logic                   fifo_full;
	logic                   fifo_empty;
	logic [`LB_COUNT_W-1:0] fifo_count;
	logic                   fifo_wr_en;
	logic                   fifo_rd_en;

	// Only the low six flag bits are decoded
	assign mmu_flags = fetch_pkg::mmu_flags_t'(prev_mmu_flags[5:0]);

	fetch_fault_check fault_check_inst (
		.paging_ena          (prev_paging_ena),
		.kernel_access       (prev_kernel_access),
		.upstream_page_fault (prev_pagefault),
		.mmu_flags           (mmu_flags),
		.inst                (prev_inst),
		.fault               (fault)
	);

	// Pack instruction with its fault bits
	always_comb begin
		wr_entry.fault               = fault;
		wr_entry.paging_ena          = prev_paging_ena;
		wr_entry.kernel_access       = prev_kernel_access;
		wr_entry.branch_predict      = prev_branch_predict;
		wr_entry.branch_predict_addr = prev_branch_predict_addr;
		wr_entry.inst                = prev_inst;
		wr_entry.pc                  = prev_pc;
	end

	assign fifo_wr_en = prev_inst_valid && !fifo_full;
	assign fifo_rd_en = !fifo_empty && !next_lock;  // Decode takes head every valid cycle

	inst_sync_fifo fifo_inst (
		.clock   (clock),
		.reset   (reset),
		.flush   (free_refresh),
		.wr_en   (fifo_wr_en),
		.wr_data (wr_entry),
		.rd_en   (fifo_rd_en),
		.rd_data (next_entry),
		.full    (fifo_full),
		.empty   (fifo_empty),
		.count   (fifo_count)
	);

	assign prev_lock       = fifo_full;
	assign prev_fetch_stop = (fifo_count > `LB_COUNT_W'(`LB_STOP_LEVEL));
	assign next_inst_valid = fifo_rd_en;

	a_no_valid_under_lock: assert property (
		@(posedge clock) disable iff (reset) next_lock |-> !next_inst_valid
	);

	// Locked head must not change until decode releases it
	a_head_held_under_lock: assert property (
		@(posedge clock) disable iff (reset)
		(next_lock && !fifo_empty && !free_refresh) |=> $stable(next_entry)
	);

endmodule

`default_nettype wire

// ==== tests/loopbuffer_tb.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module loopbuffer_tb;

	localparam int CLK_PERIOD   = 8;
	localparam int DRAIN_LIMIT  = 64;
	localparam int DELIVERY_CYC = 400;
	localparam int FAULT_CYC    = 300;
	localparam int BP_CYC       = 40 + 20 + DRAIN_LIMIT;
	localparam int FLUSH_CYC    = 40 + 2 + 60 + DRAIN_LIMIT;
	localparam int TOTAL_CYC    = 4 + DELIVERY_CYC + DRAIN_LIMIT + FAULT_CYC + DRAIN_LIMIT
		+ BP_CYC + FLUSH_CYC;

	logic                 clock;
	logic                 reset;
	logic                 free_refresh;
	logic                 prev_inst_valid;
	logic                 prev_pagefault;
	logic [13:0]          prev_mmu_flags;
	logic                 prev_paging_ena;
	logic                 prev_kernel_access;
	logic                 prev_branch_predict;
	logic [31:0]          prev_branch_predict_addr;
	logic [31:0]          prev_inst;
	logic [31:0]          prev_pc;
	logic                 next_lock;
	logic                 prev_fetch_stop;
	logic                 prev_lock;
	logic                 next_inst_valid;
	fetch_pkg::lb_entry_t next_entry;

	fetch_pkg::lb_entry_t model_q[$];  // Expected queue contents, head first
	int  accepted_cnt;
	int  delivered_cnt;
	int  dropped_cnt;
	int  err_count;
	int  test_count;
	int  failed_tests;
	int  err_base;
	bit  checking;

	loopbuffer loopbuffer_inst (
		.clock                    (clock),
		.reset                    (reset),
		.free_refresh             (free_refresh),
		.prev_inst_valid          (prev_inst_valid),
		.prev_pagefault           (prev_pagefault),
		.prev_mmu_flags           (prev_mmu_flags),
		.prev_paging_ena          (prev_paging_ena),
		.prev_kernel_access       (prev_kernel_access),
		.prev_branch_predict      (prev_branch_predict),
		.prev_branch_predict_addr (prev_branch_predict_addr),
		.prev_inst                (prev_inst),
		.prev_pc                  (prev_pc),
		.prev_fetch_stop          (prev_fetch_stop),
		.prev_lock                (prev_lock),
		.next_inst_valid          (next_inst_valid),
		.next_entry               (next_entry),
		.next_lock                (next_lock)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// Fault rule for one fetched instruction
	function automatic fetch_pkg::fault_t ref_fault(input logic paging, input logic kernel,
		input logic upf, input logic [13:0] flags, input logic [31:0] inst);
		fetch_pkg::mmu_flags_t   f;
		fetch_pkg::priv_opcode_e opc;
		fetch_pkg::fault_t       res;
		logic                    hit;
		f = fetch_pkg::mmu_flags_t'(flags[5:0]);
		hit = 1'b0;
		opc = opc.first();
		repeat (opc.num()) begin
			if (inst[`OPC_FIELD_MSB:`OPC_FIELD_LSB] == opc) begin
				hit = 1'b1;
			end
			opc = opc.next();
		end
		res.page_fault = upf || (paging && !f.valid);
		res.invalid_inst = paging && !f.exec;
		res.privilege_error = !kernel && ((paging && f.exec && f.user_level == 2'd0) || hit);
		return res;
	endfunction

	function automatic fetch_pkg::lb_entry_t entry_from_inputs();
		fetch_pkg::lb_entry_t e;
		e.fault = ref_fault(prev_paging_ena, prev_kernel_access, prev_pagefault,
			prev_mmu_flags, prev_inst);
		e.paging_ena          = prev_paging_ena;
		e.kernel_access       = prev_kernel_access;
		e.branch_predict      = prev_branch_predict;
		e.branch_predict_addr = prev_branch_predict_addr;
		e.inst                = prev_inst;
		e.pc                  = prev_pc;
		return e;
	endfunction

	// Model follows the same edge the DUT sees
	always @(posedge clock) begin
		bit push;
		bit pop;
		if (reset || free_refresh) begin
			dropped_cnt += model_q.size();
			model_q.delete();
		end else begin
			push = prev_inst_valid && (model_q.size() < `LB_DEPTH);
			pop  = (model_q.size() > 0) && !next_lock;
			if (pop) begin
				void'(model_q.pop_front());
			end
			if (next_inst_valid) begin
				delivered_cnt++;  // Counted from what the DUT hands to decode
			end
			if (push) begin
				model_q.push_back(entry_from_inputs());
				accepted_cnt++;
			end
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			err_count++;
			$display("CHECK FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clock) begin
		if (checking && !reset) begin
			check_bit("next_inst_valid", next_inst_valid, (model_q.size() > 0) && !next_lock);
			check_bit("prev_lock", prev_lock, model_q.size() == `LB_DEPTH);
			check_bit("prev_fetch_stop", prev_fetch_stop, model_q.size() > `LB_STOP_LEVEL);
			if (model_q.size() > 0) begin
				assert (next_entry.fault === model_q[0].fault) else begin
					err_count++;
					$display("CHECK FAILED next_entry.fault: got %h expected %h",
						next_entry.fault, model_q[0].fault);
				end
				assert (next_entry === model_q[0]) else begin
					err_count++;
					$display("CHECK FAILED next_entry: got %h expected %h",
						next_entry, model_q[0]);
				end
			end
		end
	end

	task automatic new_fetch(input int valid_pct, input int priv_pct);
		logic [31:0]             inst;
		fetch_pkg::priv_opcode_e opc;
		inst = $urandom;
		if ($urandom_range(99) < priv_pct) begin
			opc = opc.first();
			repeat ($urandom_range(8)) begin
				opc = opc.next();
			end
			inst[`OPC_FIELD_MSB:`OPC_FIELD_LSB] = opc;
		end
		prev_inst_valid          <= ($urandom_range(99) < valid_pct);
		prev_inst                <= inst;
		prev_pc                  <= $urandom & 32'hffff_fffc;
		prev_mmu_flags           <= 14'($urandom);
		prev_paging_ena          <= 1'($urandom_range(1));
		prev_kernel_access       <= 1'($urandom_range(1));
		prev_pagefault           <= ($urandom_range(7) == 0);
		prev_branch_predict      <= 1'($urandom_range(1));
		prev_branch_predict_addr <= $urandom;
	endtask

	// Fetch keeps a refused instruction until it gets in
	task automatic drive_cycles(input int n, input int valid_pct, input int lock_pct,
		input int priv_pct);
		repeat (n) begin
			@(posedge clock);
			if (!prev_inst_valid || !prev_lock) begin
				new_fetch(valid_pct, priv_pct);
			end
			next_lock    <= ($urandom_range(99) < lock_pct);
			free_refresh <= 1'b0;
		end
	endtask

	task automatic drain_queue();
		int waited;
		waited = 0;
		@(posedge clock);
		prev_inst_valid <= 1'b0;
		next_lock       <= 1'b0;
		free_refresh    <= 1'b0;
		while (model_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(posedge clock);
			waited++;
		end
		@(negedge clock);
		if (model_q.size() > 0) begin
			err_count++;
			$display("Queue did not drain within %0d cycles", DRAIN_LIMIT);
		end
		assert (accepted_cnt == delivered_cnt + dropped_cnt) else begin
			err_count++;
			$display("Entries lost: %0d accepted, %0d delivered, %0d flushed",
				accepted_cnt, delivered_cnt, dropped_cnt);
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count == err_base) begin
			$display("test %s: PASS", name);
		end else begin
			failed_tests++;
			$display("test %s: FAIL (%0d errors)", name, err_count - err_base);
		end
		err_base = err_count;
	endtask

	initial begin
		#(TOTAL_CYC * CLK_PERIOD * 2);
		$display("Watchdog timeout: the run exceeded its cycle budget");
		$display("Test failures found");
		$finish;
	end

	initial begin
		void'($urandom(9642));
		reset = 1'b1;
		free_refresh = 1'b0;
		prev_inst_valid = 1'b0;
		prev_pagefault = 1'b0;
		prev_mmu_flags = '0;
		prev_paging_ena = 1'b0;
		prev_kernel_access = 1'b0;
		prev_branch_predict = 1'b0;
		prev_branch_predict_addr = '0;
		prev_inst = '0;
		prev_pc = '0;
		next_lock = 1'b0;

		// Reset state
		@(posedge clock);
		@(negedge clock);
		check_bit("next_inst_valid", next_inst_valid, 1'b0);
		check_bit("prev_lock", prev_lock, 1'b0);
		check_bit("prev_fetch_stop", prev_fetch_stop, 1'b0);
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_bit("next_inst_valid", next_inst_valid, 1'b0);
		check_bit("prev_lock", prev_lock, 1'b0);
		check_bit("prev_fetch_stop", prev_fetch_stop, 1'b0);
		checking = 1'b1;
		finish_test("reset_state");

		drive_cycles(DELIVERY_CYC, 70, 40, 10);
		drain_queue();
		finish_test("in_order_delivery");

		drive_cycles(FAULT_CYC, 80, 20, 50);  // Many privileged opcodes
		drain_queue();
		finish_test("fault_classification");

		// Decode locked while fetch keeps pushing
		drive_cycles(40, 100, 100, 10);
		@(negedge clock);
		check_bit("prev_lock", prev_lock, 1'b1);
		check_bit("prev_fetch_stop", prev_fetch_stop, 1'b1);
		drive_cycles(20, 100, 0, 10);
		drain_queue();
		finish_test("back_pressure");

		drive_cycles(40, 90, 80, 10);
		@(posedge clock);
		new_fetch(100, 10);
		next_lock    <= 1'b0;
		free_refresh <= 1'b1;  // Flush with a write and a read pending
		@(posedge clock);
		free_refresh    <= 1'b0;
		prev_inst_valid <= 1'b0;
		@(negedge clock);
		check_bit("next_inst_valid", next_inst_valid, 1'b0);
		check_bit("prev_fetch_stop", prev_fetch_stop, 1'b0);
		drive_cycles(60, 70, 30, 10);
		drain_queue();
		finish_test("flush");

		$display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
			err_count);
		if (err_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+src
src/fetch_pkg.sv
src/fetch_fault_check.sv
src/inst_sync_fifo.sv
src/loopbuffer.sv
tests/loopbuffer_tb.sv
